// File: flist.f
src/rvIsaPkg.sv
src/rvPipePkg.sv
src/pipeIfs.sv
src/hazardControl.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memWriteback.sv
src/rvCoreTop.sv
verification/clockGen.sv
verification/coreTb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench, exit status reflects the result
verilator --binary -f flist.f --top-module coreTb -o coreSim \
    && ./obj_dir/coreSim \
    || exit 1

// File: src/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
    input  logic             clk,
    input  logic             rst,
    input  rvPipePkg::ifIdT  ifId,
    output rvPipePkg::idExT  idEx,
    hazardIf.decode          hz,
    writebackIf.decode       wb
);
    rvIsaPkg::wordT    instr;
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              isSub;
    rvIsaPkg::regIdxT  rs1;
    rvIsaPkg::regIdxT  rs2;
    rvIsaPkg::regIdxT  rd;
    rvPipePkg::ctrlT   ctrl;
    rvIsaPkg::aluOpT   aluFunc;
    rvIsaPkg::immKindT immKind;
    rvIsaPkg::wordT    immExt;
    rvIsaPkg::wordT    rd1;
    rvIsaPkg::wordT    rd2;
    rvIsaPkg::wordT    regs [32];

    // x0 reads zero, same-cycle write passes straight through
    function automatic rvIsaPkg::wordT readPort(
        input rvIsaPkg::regIdxT idx,
        input rvIsaPkg::wordT   stored,
        input logic             we,
        input rvIsaPkg::regIdxT wIdx,
        input rvIsaPkg::wordT   wData
    );
        if (idx == '0)
            return '0;
        if (we && wIdx == idx)
            return wData;
        return stored;
    endfunction

    assign instr  = ifId.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign isSub  = (opcode == rvIsaPkg::OP_REG) && instr[30];   // sub, not addi
    assign rs1    = (opcode == rvIsaPkg::OP_LUI) ? '0 : instr[19:15];  // lui adds to x0
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];

    assign hz.rs1D = rs1;
    assign hz.rs2D = rs2;

    ////////////////////////////////////////////////////////////
    // ALU decoder, funct3 plus bit 30
    always_comb begin
        case (funct3)
            3'b000:  aluFunc = isSub ? rvIsaPkg::ALU_SUB : rvIsaPkg::ALU_ADD;
            3'b001:  aluFunc = rvIsaPkg::ALU_SLL;
            3'b010:  aluFunc = rvIsaPkg::ALU_SLT;
            3'b011:  aluFunc = rvIsaPkg::ALU_SLTU;
            3'b100:  aluFunc = rvIsaPkg::ALU_XOR;
            3'b101:  aluFunc = instr[30] ? rvIsaPkg::ALU_SRA : rvIsaPkg::ALU_SRL;
            3'b110:  aluFunc = rvIsaPkg::ALU_OR;
            default: aluFunc = rvIsaPkg::ALU_AND;
        endcase
    end

    // main decoder, unknown opcodes stay a bubble
    always_comb begin
        ctrl    = '0;
        immKind = rvIsaPkg::IMM_I;
        case (opcode)
            rvIsaPkg::OP_LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;   // base + offset
                ctrl.resultSrc = rvPipePkg::RES_MEM;
            end
            rvIsaPkg::OP_STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immKind       = rvIsaPkg::IMM_S;
            end
            rvIsaPkg::OP_REG: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFunc;
            end
            rvIsaPkg::OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluFunc;
            end
            rvIsaPkg::OP_BRANCH: begin
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = rvIsaPkg::ALU_SUB;   // compare via flags
                ctrl.brFunct3 = funct3;
                immKind       = rvIsaPkg::IMM_B;
            end
            rvIsaPkg::OP_JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = rvPipePkg::RES_PC4;   // link
                immKind        = rvIsaPkg::IMM_J;
            end
            rvIsaPkg::OP_LUI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                immKind       = rvIsaPkg::IMM_U;
            end
            default: ;
        endcase
    end

    // immediate extender
    always_comb begin
        case (immKind)
            rvIsaPkg::IMM_S: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvIsaPkg::IMM_B: immExt = {{20{instr[31]}}, instr[7], instr[30:25],
                                       instr[11:8], 1'b0};
            rvIsaPkg::IMM_J: immExt = {{12{instr[31]}}, instr[19:12], instr[20],
                                       instr[30:21], 1'b0};
            rvIsaPkg::IMM_U: immExt = {instr[31:12], 12'b0};
            default:         immExt = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    ////////////////////////////////////////////////////////////
    // register file, write on the rising edge
    always_ff @(posedge clk) begin
        if (wb.regWriteW && wb.rdW != '0) begin
            regs[wb.rdW] <= wb.resultW;
        end
    end

    assign rd1 = readPort(rs1, regs[rs1], wb.regWriteW, wb.rdW, wb.resultW);
    assign rd2 = readPort(rs2, regs[rs2], wb.regWriteW, wb.rdW, wb.resultW);

    // ID/EX
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idEx <= '0;
        end else if (hz.flushE) begin
            idEx <= '0;          // load-use bubble or redirect
        end else begin
            idEx.ctrl    <= ctrl;
            idEx.pc      <= ifId.pc;
            idEx.pcPlus4 <= ifId.pc + 32'd4;
            idEx.rd1     <= rd1;
            idEx.rd2     <= rd2;
            idEx.immExt  <= immExt;
            idEx.rs1     <= rs1;
            idEx.rs2     <= rs2;
            idEx.rd      <= rd;
        end
    end

endmodule

`default_nettype wire

// File: src/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  rvPipePkg::idExT  idEx,
    output rvPipePkg::exMemT exMem,
    output logic             pcSrc,
    output rvIsaPkg::wordT   pcTarget,
    hazardIf.execute         hz,
    writebackIf.execute      wb
);
    rvIsaPkg::wordT srcA;
    rvIsaPkg::wordT fwdB;       // also the store data
    rvIsaPkg::wordT srcB;
    rvIsaPkg::wordT addend;
    rvIsaPkg::wordT sum;
    rvIsaPkg::wordT aluResult;
    logic           subtract;
    logic           carry;
    logic           overflow;
    logic           negative;
    logic           zero;
    logic           brCond;

    function automatic rvIsaPkg::wordT pickOperand(
        input rvPipePkg::fwdSelT sel,
        input rvIsaPkg::wordT    regVal,
        input rvIsaPkg::wordT    memVal,
        input rvIsaPkg::wordT    wbVal
    );
        case (sel)
            rvPipePkg::FWD_FROM_MEM: return memVal;
            rvPipePkg::FWD_FROM_WB:  return wbVal;
            default:                 return regVal;
        endcase
    endfunction

    assign hz.rs1E   = idEx.rs1;
    assign hz.rs2E   = idEx.rs2;
    assign hz.rdE    = idEx.rd;
    assign hz.loadE  = (idEx.ctrl.resultSrc == rvPipePkg::RES_MEM);
    assign hz.pcSrcE = pcSrc;

    ////////////////////////////////////////////////////////////
    // operand muxes
    assign srcA = pickOperand(hz.fwdA, idEx.rd1, wb.aluResultM, wb.resultW);
    assign fwdB = pickOperand(hz.fwdB, idEx.rd2, wb.aluResultM, wb.resultW);
    assign srcB = idEx.ctrl.aluSrc ? idEx.immExt : fwdB;

    // shared adder does a - b as a + ~b + 1
    assign subtract = idEx.ctrl.aluOp inside {rvIsaPkg::ALU_SUB, rvIsaPkg::ALU_SLT,
                                              rvIsaPkg::ALU_SLTU};
    assign addend   = subtract ? ~srcB : srcB;
    assign {carry, sum} = {1'b0, srcA} + {1'b0, addend} + 33'(subtract);

    assign overflow = (srcA[31] == addend[31]) && (sum[31] != srcA[31]);
    assign negative = sum[31];
    assign zero     = (sum == '0);

    always_comb begin
        case (idEx.ctrl.aluOp)
            rvIsaPkg::ALU_SUB:  aluResult = sum;
            rvIsaPkg::ALU_AND:  aluResult = srcA & srcB;
            rvIsaPkg::ALU_OR:   aluResult = srcA | srcB;
            rvIsaPkg::ALU_XOR:  aluResult = srcA ^ srcB;
            rvIsaPkg::ALU_SLT:  aluResult = {31'd0, negative ^ overflow};
            rvIsaPkg::ALU_SLTU: aluResult = {31'd0, ~carry};   // borrow out
            rvIsaPkg::ALU_SLL:  aluResult = srcA << srcB[4:0];
            rvIsaPkg::ALU_SRL:  aluResult = srcA >> srcB[4:0];
            rvIsaPkg::ALU_SRA:  aluResult = $signed(srcA) >>> srcB[4:0];
            default:            aluResult = sum;               // add
        endcase
    end

    // branch condition from the subtract flags
    always_comb begin
        case (idEx.ctrl.brFunct3)
            rvIsaPkg::BR_EQ:  brCond = zero;
            rvIsaPkg::BR_NE:  brCond = ~zero;
            rvIsaPkg::BR_LT:  brCond = negative ^ overflow;
            rvIsaPkg::BR_GE:  brCond = ~(negative ^ overflow);
            rvIsaPkg::BR_LTU: brCond = ~carry;
            rvIsaPkg::BR_GEU: brCond = carry;
            default:          brCond = 1'b0;
        endcase
    end

    assign pcSrc    = (idEx.ctrl.branch && brCond) || idEx.ctrl.jump;
    assign pcTarget = idEx.pc + idEx.immExt;   // branch and jal alike

    // EX/MEM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exMem <= '0;
        end else begin
            exMem.regWrite  <= idEx.ctrl.regWrite;
            exMem.memWrite  <= idEx.ctrl.memWrite;
            exMem.resultSrc <= idEx.ctrl.resultSrc;
            exMem.aluResult <= aluResult;
            exMem.writeData <= fwdB;
            exMem.pcPlus4   <= idEx.pcPlus4;
            exMem.rd        <= idEx.rd;
        end
    end

endmodule

`default_nettype wire

// File: src/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pcSrc,
    input  rvIsaPkg::wordT               pcTarget,
    input  rvIsaPkg::wordT               imemData,
    output logic [rvIsaPkg::IMEM_AW-1:0] imemAddr,
    output rvPipePkg::ifIdT              ifId,
    hazardIf.fetch                       hz
);
    rvIsaPkg::wordT pc;
    rvIsaPkg::wordT pcNext;

    assign pcNext   = pcSrc ? pcTarget : pc + 32'd4;
    assign imemAddr = pc[rvIsaPkg::IMEM_AW+1:2];   // word address, async read

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (!hz.stallF) begin
            pc <= pcNext;
        end
    end

    ////////////////////////////////////////////////////////////
    // IF/ID, the all-zero word decodes as a bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ifId <= '0;
        end else if (hz.flushD) begin
            ifId <= '0;
        end else if (!hz.stallD) begin
            ifId.pc    <= pc;
            ifId.instr <= imemData;
        end
    end

endmodule

`default_nettype wire

// File: src/hazardControl.sv
`timescale 1ns/1ps
`default_nettype none

module hazardControl (
    hazardIf.control hz
);
    logic loadUse;

    // newest producer wins, x0 never forwarded
    function automatic rvPipePkg::fwdSelT pickFwd(
        input rvIsaPkg::regIdxT rs,
        input rvIsaPkg::regIdxT rdM,
        input logic             wrM,
        input rvIsaPkg::regIdxT rdW,
        input logic             wrW
    );
        if (rs != '0 && rs == rdM && wrM)
            return rvPipePkg::FWD_FROM_MEM;
        if (rs != '0 && rs == rdW && wrW)
            return rvPipePkg::FWD_FROM_WB;
        return rvPipePkg::FWD_REG;
    endfunction

    assign hz.fwdA = pickFwd(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.fwdB = pickFwd(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);

    // lw in EX, consumer in ID
    assign loadUse = hz.loadE && (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

    assign hz.stallF = loadUse;
    assign hz.stallD = loadUse;
    assign hz.flushD = hz.pcSrcE;             // drop wrong-path fetch
    assign hz.flushE = loadUse || hz.pcSrcE;  // bubble into EX

endmodule

`default_nettype wire

// File: src/memWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module memWriteback (
    input  logic                         clk,
    input  logic                         rst,
    input  rvPipePkg::exMemT             exMem,
    input  rvIsaPkg::wordT               dmemReadData,
    output logic [rvIsaPkg::DMEM_AW-1:0] dmemAddr,
    output rvIsaPkg::wordT               dmemWriteData,
    output logic                         dmemWriteEn,
    hazardIf.memWb                       hz,
    writebackIf.source                   wb
);
    logic                 regWriteW;
    rvPipePkg::resultSrcT resultSrcW;
    rvIsaPkg::regIdxT     rdW;
    rvIsaPkg::wordT       readDataW;
    rvIsaPkg::wordT       aluResultW;
    rvIsaPkg::wordT       pcPlus4W;

    // word accesses only, low address bits ignored
    assign dmemAddr      = exMem.aluResult[rvIsaPkg::DMEM_AW+1:2];
    assign dmemWriteData = exMem.writeData;
    assign dmemWriteEn   = exMem.memWrite;

    assign hz.rdM       = exMem.rd;
    assign hz.regWriteM = exMem.regWrite;
    assign wb.aluResultM = exMem.aluResult;   // MEM-stage forward

    ////////////////////////////////////////////////////////////
    // MEM/WB
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regWriteW  <= 1'b0;
            resultSrcW <= rvPipePkg::RES_ALU;
            rdW        <= '0;
        end else begin
            regWriteW  <= exMem.regWrite;
            resultSrcW <= exMem.resultSrc;
            rdW        <= exMem.rd;
        end
    end

    always_ff @(posedge clk) begin
        readDataW  <= dmemReadData;
        aluResultW <= exMem.aluResult;
        pcPlus4W   <= exMem.pcPlus4;
    end

    always_comb begin
        case (resultSrcW)
            rvPipePkg::RES_MEM: wb.resultW = readDataW;
            rvPipePkg::RES_PC4: wb.resultW = pcPlus4W;   // jal link
            default:            wb.resultW = aluResultW;
        endcase
    end

    assign wb.regWriteW = regWriteW;
    assign wb.rdW       = rdW;
    assign hz.regWriteW = regWriteW;
    assign hz.rdW       = rdW;

endmodule

`default_nettype wire

// File: src/pipeIfs.sv
`timescale 1ns/1ps
`default_nettype none

// hazard unit and the four stages
interface hazardIf;
    rvIsaPkg::regIdxT  rs1D;
    rvIsaPkg::regIdxT  rs2D;
    rvIsaPkg::regIdxT  rs1E;
    rvIsaPkg::regIdxT  rs2E;
    rvIsaPkg::regIdxT  rdE;
    logic              loadE;
    logic              pcSrcE;   // taken branch or jal
    rvIsaPkg::regIdxT  rdM;
    logic              regWriteM;
    rvIsaPkg::regIdxT  rdW;
    logic              regWriteW;
    logic              stallF;
    logic              stallD;
    logic              flushD;
    logic              flushE;
    rvPipePkg::fwdSelT fwdA;
    rvPipePkg::fwdSelT fwdB;

    modport control (
        input  rs1D, rs2D, rs1E, rs2E, rdE, loadE, pcSrcE,
        input  rdM, regWriteM, rdW, regWriteW,
        output stallF, stallD, flushD, flushE, fwdA, fwdB
    );
    modport fetch   (input stallF, stallD, flushD);
    modport decode  (output rs1D, rs2D, input flushE);
    modport execute (output rs1E, rs2E, rdE, loadE, pcSrcE, input fwdA, fwdB);
    modport memWb   (output rdM, regWriteM, rdW, regWriteW);
endinterface

// register file write port plus forwarded results
interface writebackIf;
    logic             regWriteW;
    rvIsaPkg::regIdxT rdW;
    rvIsaPkg::wordT   resultW;
    rvIsaPkg::wordT   aluResultM;

    modport source  (output regWriteW, rdW, resultW, aluResultM);
    modport decode  (input regWriteW, rdW, resultW);
    modport execute (input resultW, aluResultM);
endinterface

`default_nettype wire

// File: src/rvCoreTop.sv
`timescale 1ns/1ps
`default_nettype none

module rvCoreTop (
    input  logic                         clk,
    input  logic                         rst,
    // instruction memory, async read
    output logic [rvIsaPkg::IMEM_AW-1:0] imemAddr,
    input  rvIsaPkg::wordT               imemData,
    // data memory, write on next rising edge
    output logic [rvIsaPkg::DMEM_AW-1:0] dmemAddr,
    output rvIsaPkg::wordT               dmemWriteData,
    output logic                         dmemWriteEn,
    input  rvIsaPkg::wordT               dmemReadData
);
    rvPipePkg::ifIdT  ifId;
    rvPipePkg::idExT  idEx;
    rvPipePkg::exMemT exMem;
    logic             pcSrc;
    rvIsaPkg::wordT   pcTarget;

    hazardIf    hz ();
    writebackIf wb ();

    ////////////////////////////////////////////////////////////
    hazardControl hazardCtrl (
        .hz (hz)
    );

    fetchStage fetch (
        .clk      (clk),
        .rst      (rst),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .imemData (imemData),
        .imemAddr (imemAddr),
        .ifId     (ifId),
        .hz       (hz)
    );

    decodeStage decode (
        .clk  (clk),
        .rst  (rst),
        .ifId (ifId),
        .idEx (idEx),
        .hz   (hz),
        .wb   (wb)
    );

    executeStage execute (
        .clk      (clk),
        .rst      (rst),
        .idEx     (idEx),
        .exMem    (exMem),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .hz       (hz),
        .wb       (wb)
    );

    memWriteback memWb (
        .clk           (clk),
        .rst           (rst),
        .exMem         (exMem),
        .dmemReadData  (dmemReadData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWriteEn   (dmemWriteEn),
        .hz            (hz),
        .wb            (wb)
    );

endmodule

`default_nettype wire

// File: src/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    localparam int XLEN    = 32;
    localparam int IMEM_AW = 10;   // instruction memory, word address
    localparam int DMEM_AW = 10;   // data memory, word address

    typedef logic [XLEN-1:0] wordT;
    typedef logic [4:0]      regIdxT;

    ////////////////////////////////////////////////////////////
    // major opcodes, instr[6:0]
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // immediate layouts
    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } immKindT;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } aluOpT;

    // branch funct3
    localparam logic [2:0] BR_EQ  = 3'b000;
    localparam logic [2:0] BR_NE  = 3'b001;
    localparam logic [2:0] BR_LT  = 3'b100;
    localparam logic [2:0] BR_GE  = 3'b101;
    localparam logic [2:0] BR_LTU = 3'b110;
    localparam logic [2:0] BR_GEU = 3'b111;

endpackage

`default_nettype wire

// File: src/rvPipePkg.sv
`default_nettype none

package rvPipePkg;

    // what writeback puts in rd
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } resultSrcT;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_FROM_WB,
        FWD_FROM_MEM
    } fwdSelT;

    // all zeros is a bubble
    typedef struct packed {
        logic                regWrite;
        logic                memWrite;
        logic                jump;
        logic                branch;
        logic                aluSrc;    // srcB from immediate
        resultSrcT           resultSrc;
        rvIsaPkg::aluOpT     aluOp;
        logic [2:0]          brFunct3;
    } ctrlT;

    ////////////////////////////////////////////////////////////
    // stage registers
    typedef struct packed {
        rvIsaPkg::wordT pc;
        rvIsaPkg::wordT instr;
    } ifIdT;

    typedef struct packed {
        ctrlT             ctrl;
        rvIsaPkg::wordT   pc;
        rvIsaPkg::wordT   pcPlus4;
        rvIsaPkg::wordT   rd1;
        rvIsaPkg::wordT   rd2;
        rvIsaPkg::wordT   immExt;
        rvIsaPkg::regIdxT rs1;
        rvIsaPkg::regIdxT rs2;
        rvIsaPkg::regIdxT rd;
    } idExT;

    typedef struct packed {
        logic             regWrite;
        logic             memWrite;
        resultSrcT        resultSrc;
        rvIsaPkg::wordT   aluResult;
        rvIsaPkg::wordT   writeData;   // store data after forwarding
        rvIsaPkg::wordT   pcPlus4;
        rvIsaPkg::regIdxT rd;
    } exMemT;

endpackage

`default_nettype wire

// File: verification/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // reset held for 8 rising edges, released just after the edge
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
    end
endmodule

`default_nettype wire

// File: verification/coreStimulus.txt
# tag addr word : I = instruction word, D = data preset, S = expected store
# addresses are word addresses, values in hex
I 00 12300093
I 01 FFB00113
I 02 002081B3
I 03 00302023
I 04 40208233
I 05 00402223
I 06 001122B3
I 07 00113333
I 08 00502423
I 09 00602623
I 0A 401153B3
I 0B 00115433
I 0C 00702823
I 0D 00802A23
I 0E 001094B3
I 0F 0020C533
I 10 0020E5B3
I 11 0020F633
I 12 00902C23
I 13 00A02E23
I 14 02B02023
I 15 02C02223
I 16 ABCDE6B7
I 17 FFC12713
I 18 4046D793
I 19 02D02423
I 1A 02E02623
I 1B 02F02823
I 1C 20002803
I 1D 05580893
I 1E 03102A23
I 1F FFF00F93
I 20 00208463
I 21 02102C23
I 22 00108663
I 23 11F02023
I 24 11F02023
I 25 00109463
I 26 02102E23
I 27 00209663
I 28 11F02023
I 29 11F02023
I 2A 0020C463
I 2B 04102023
I 2C 00114663
I 2D 11F02023
I 2E 11F02023
I 2F 00115463
I 30 04102223
I 31 0020D663
I 32 11F02023
I 33 11F02023
I 34 00116463
I 35 04102423
I 36 0020E663
I 37 11F02023
I 38 11F02023
I 39 0020F463
I 3A 04102623
I 3B 00117663
I 3C 11F02023
I 3D 11F02023
I 3E 00C0096F
I 3F 11F02023
I 40 11F02023
I 41 05202823
I 42 0000006F
D 80 00001000
S 00 0000011E
S 01 00000128
S 02 00000001
S 03 00000000
S 04 FFFFFFFF
S 05 1FFFFFFF
S 06 00000918
S 07 FFFFFED8
S 08 FFFFFFFB
S 09 00000123
S 0A ABCDE000
S 0B 00000001
S 0C FABCDE00
S 0D 00001055
S 0E 00000123
S 0F 00000123
S 10 00000123
S 11 00000123
S 12 00000123
S 13 00000123
S 14 000000FC

// File: verification/coreTb.sv
`timescale 1ns/1ps
`default_nettype none

module coreTb;
    logic                         clk;
    logic                         rst;
    logic [rvIsaPkg::IMEM_AW-1:0] imemAddr;
    rvIsaPkg::wordT               imemData;
    logic [rvIsaPkg::DMEM_AW-1:0] dmemAddr;
    rvIsaPkg::wordT               dmemWriteData;
    logic                         dmemWriteEn;
    rvIsaPkg::wordT               dmemReadData;

    rvIsaPkg::wordT imem [1 << rvIsaPkg::IMEM_AW];
    rvIsaPkg::wordT dmem [1 << rvIsaPkg::DMEM_AW];

    // expected stores in program order
    logic [rvIsaPkg::DMEM_AW-1:0] expAddr [$];
    rvIsaPkg::wordT               expData [$];
    int                           storeIdx = 0;
    int                           numInstr = 0;
    int                           cycles   = 0;
    int                           cycleLimit = 0;
    logic                         loaded   = 1'b0;

    clockGen clkGen (
        .clk (clk),
        .rst (rst)
    );

    rvCoreTop dut_i (
        .clk           (clk),
        .rst           (rst),
        .imemAddr      (imemAddr),
        .imemData      (imemData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWriteEn   (dmemWriteEn),
        .dmemReadData  (dmemReadData)
    );

    ////////////////////////////////////////////////////////////
    // memory models read asynchronously
    assign imemData     = imem[imemAddr];
    assign dmemReadData = dmem[dmemAddr];

    always @(posedge clk) begin
        if (dmemWriteEn) begin
            dmem[dmemAddr] <= dmemWriteData;   // lands on the edge
        end
    end

    ////////////////////////////////////////////////////////////
    // failure reporting
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input rvIsaPkg::wordT got,
                             input rvIsaPkg::wordT exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkAddr(input string name, input logic [rvIsaPkg::DMEM_AW-1:0] got,
                             input logic [rvIsaPkg::DMEM_AW-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkFetch(input string name, input logic [rvIsaPkg::IMEM_AW-1:0] got,
                              input logic [rvIsaPkg::IMEM_AW-1:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkEnable(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus file holds tag then word address then word
    task automatic loadStimulus();
        int             fd;
        int             n;
        string          line;
        byte            tag;
        logic [31:0]    addr;
        rvIsaPkg::wordT word;
        fd = $fopen("verification/coreStimulus.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open the stimulus file");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 1 && line[0] != "#") begin
                    n = $sscanf(line, "%c %h %h", tag, addr, word);
                    if (n == 3) begin
                        case (tag)
                            "I": begin
                                imem[addr[rvIsaPkg::IMEM_AW-1:0]] = word;
                                numInstr++;
                            end
                            "D": dmem[addr[rvIsaPkg::DMEM_AW-1:0]] = word;
                            "S": begin
                                expAddr.push_back(addr[rvIsaPkg::DMEM_AW-1:0]);
                                expData.push_back(word);
                            end
                            default: abortRun("unknown tag in the stimulus file");
                        endcase
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // store checker samples mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (!rst && loaded && dmemWriteEn) begin
            if (storeIdx >= expData.size()) begin
                abortRun("a store happened after the last expected one");
            end else begin
                checkAddr("dmemAddr", dmemAddr, expAddr[storeIdx]);
                checkWord("dmemWriteData", dmemWriteData, expData[storeIdx]);
                storeIdx++;
            end
        end
    end

    // cycle limit scales with program length
    always @(posedge clk) begin
        if (!rst && loaded) begin
            cycles++;
            if (cycles >= cycleLimit) begin
                $display("timeout after %0d cycles, %0d stores still missing",
                         cycles, expData.size() - storeIdx);
                $display("Verification failed");
                $fatal(1);
            end
        end
    end

    initial begin
        int i;
        for (i = 0; i < (1 << rvIsaPkg::IMEM_AW); i++) begin
            imem[i] = '0;                          // bubbles
        end
        for (i = 0; i < (1 << rvIsaPkg::DMEM_AW); i++) begin
            dmem[i] = rvIsaPkg::wordT'(i) * 32'h9E3779B1;  // address hash
        end
        loadStimulus();
        cycleLimit = 20 * numInstr + 200;
        loaded     = 1'b1;

        // reset window plus first cycle after it
        @(negedge clk);
        while (rst) begin
            checkEnable("dmemWriteEn", dmemWriteEn, 1'b0);
            checkFetch("imemAddr", imemAddr, '0);
            @(negedge clk);
        end
        checkEnable("dmemWriteEn", dmemWriteEn, 1'b0);
        checkFetch("imemAddr", imemAddr, '0);

        wait (storeIdx == expData.size());
        repeat (20) @(posedge clk);   // quiet window without stray stores
        $display("Verification passed");
        $finish;
    end
endmodule

`default_nettype wire
